// File: rtl/matrix_io_pkg.sv
package matrix_io_pkg;

    // ========================================================================
    // data widths
    // ========================================================================
    typedef logic [7:0] elem_t;      // one element or one parsed number
    typedef logic [2:0] dim_t;       // row / column count, 1..5
    typedef logic [1:0] slot_t;      // slot index
    typedef logic [4:0] elem_idx_t;  // row-major element index, 0..24

    // ========================================================================
    // state machines
    // ========================================================================
    typedef enum logic [1:0] {
        rx_get_rows,
        rx_get_cols,
        rx_get_data,
        rx_config
    } rx_state_t;

    typedef enum logic [3:0] {
        tx_idle,
        tx_load,
        tx_hundreds, tx_wait_hundreds,
        tx_tens,     tx_wait_tens,
        tx_units,    tx_wait_units,
        tx_space,    tx_wait_space,
        tx_cr,       tx_wait_cr,
        tx_lf,       tx_wait_lf
    } tx_state_t;

    // character codes
    localparam elem_t ascii_zero  = 8'h30;
    localparam elem_t ascii_space = 8'h20;
    localparam elem_t ascii_cr    = 8'h0d;
    localparam elem_t ascii_lf    = 8'h0a;

endpackage

// File: rtl/ascii_num_parser.sv
`timescale 1ns/10ps

module ascii_num_parser (
    input  logic                 clk,
    input  logic                 rst_n,
    input  matrix_io_pkg::elem_t rx_data,
    input  logic                 rx_done,
    output matrix_io_pkg::elem_t num_value,
    output logic                 num_valid
);

    matrix_io_pkg::elem_t digit_off;
    logic                 is_digit;
    logic                 is_delim;
    logic                 in_number;   // at least one digit since last delimiter

    // chars below '0' wrap to large values, so one compare covers the range
    assign digit_off = rx_data - matrix_io_pkg::ascii_zero;
    assign is_digit  = (digit_off < 8'd10);
    assign is_delim  = (rx_data == matrix_io_pkg::ascii_space) ||
                       (rx_data == matrix_io_pkg::ascii_cr)    ||
                       (rx_data == matrix_io_pkg::ascii_lf);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            num_value <= '0;
            num_valid <= 1'b0;
            in_number <= 1'b0;
        end else begin
            num_valid <= 1'b0;   // strobe
            if (rx_done) begin
                if (is_digit) begin
                    in_number <= 1'b1;
                    if (in_number)
                        num_value <= num_value * 8'd10 + digit_off;  // mod 256
                    else
                        num_value <= digit_off;                      // first digit
                end else if (is_delim && in_number) begin
                    num_valid <= 1'b1;
                    in_number <= 1'b0;
                end
            end
        end
    end

endmodule

// File: rtl/matrix_store.sv
`timescale 1ns/10ps

module matrix_store #(
    parameter int max_slots = 4,
    parameter int max_dim   = 5
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  matrix_io_pkg::elem_t     num_value,
    input  logic                     num_valid,
    input  logic                     config_en,
    input  matrix_io_pkg::slot_t     rd_slot,
    input  matrix_io_pkg::elem_idx_t rd_idx,
    output matrix_io_pkg::elem_t     rd_elem,
    output matrix_io_pkg::dim_t      rd_rows,
    output matrix_io_pkg::dim_t      rd_cols,
    output logic [3:0]               slot_valid
);

    localparam int depth       = max_dim * max_dim;
    localparam int default_cnt = (max_slots < 2) ? max_slots : 2;

    // ========================================================================
    // slot memory
    // ========================================================================
    matrix_io_pkg::elem_t slot_mem  [max_slots][depth];
    matrix_io_pkg::dim_t  slot_rows [max_slots];
    matrix_io_pkg::dim_t  slot_cols [max_slots];

    matrix_io_pkg::rx_state_t rx_state;
    matrix_io_pkg::slot_t     wr_ptr;
    logic [2:0]               slot_cnt;    // slots in use, 1..max_slots
    matrix_io_pkg::dim_t      cur_rows;
    matrix_io_pkg::dim_t      cur_cols;
    matrix_io_pkg::elem_idx_t data_cnt;
    matrix_io_pkg::elem_idx_t last_idx;
    logic                     dim_ok;
    logic                     wr_en;
    logic                     last_elem;

    assign dim_ok    = (num_value >= 8'd1) && (num_value <= 8'(max_dim));
    assign last_idx  = matrix_io_pkg::elem_idx_t'(cur_rows) *
                       matrix_io_pkg::elem_idx_t'(cur_cols) - 5'd1;
    // config_en high in get_data means abort, so nothing is written
    assign wr_en     = num_valid && !config_en && (rx_state == matrix_io_pkg::rx_get_data);
    assign last_elem = wr_en && (data_cnt == last_idx);

    always_ff @(posedge clk) begin
        if (wr_en)
            slot_mem[wr_ptr][data_cnt] <= num_value;
        if (last_elem) begin
            slot_rows[wr_ptr] <= cur_rows;   // dims only committed on a full matrix
            slot_cols[wr_ptr] <= cur_cols;
        end
    end

    // combinational read port for the printer
    assign rd_elem = slot_mem[rd_slot][rd_idx];
    assign rd_rows = slot_rows[rd_slot];
    assign rd_cols = slot_cols[rd_slot];

    // ========================================================================
    // receive FSM
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_state   <= matrix_io_pkg::rx_get_rows;
            wr_ptr     <= '0;
            slot_cnt   <= 3'(default_cnt);
            slot_valid <= '0;
            cur_rows   <= '0;
            cur_cols   <= '0;
            data_cnt   <= '0;
        end else if (config_en && rx_state != matrix_io_pkg::rx_config) begin
            rx_state <= matrix_io_pkg::rx_config;   // drops a partial matrix
        end else if (!config_en && rx_state == matrix_io_pkg::rx_config) begin
            rx_state <= matrix_io_pkg::rx_get_rows;
        end else if (num_valid) begin
            case (rx_state)
                matrix_io_pkg::rx_get_rows: begin
                    cur_rows <= matrix_io_pkg::dim_t'(num_value);
                    if (dim_ok)
                        rx_state <= matrix_io_pkg::rx_get_cols;
                end
                matrix_io_pkg::rx_get_cols: begin
                    cur_cols <= matrix_io_pkg::dim_t'(num_value);
                    data_cnt <= '0;
                    rx_state <= dim_ok ? matrix_io_pkg::rx_get_data
                                       : matrix_io_pkg::rx_get_rows;
                end
                matrix_io_pkg::rx_get_data: begin
                    if (last_elem) begin
                        slot_valid[wr_ptr] <= 1'b1;
                        if ({1'b0, wr_ptr} >= slot_cnt - 3'd1)
                            wr_ptr <= '0;           // wrap round-robin
                        else
                            wr_ptr <= wr_ptr + 2'd1;
                        rx_state <= matrix_io_pkg::rx_get_rows;
                    end else begin
                        data_cnt <= data_cnt + 5'd1;
                    end
                end
                matrix_io_pkg::rx_config: begin
                    if (num_value == 8'd0)
                        slot_cnt <= 3'd1;
                    else if (num_value > 8'(max_slots))
                        slot_cnt <= 3'(max_slots);
                    else
                        slot_cnt <= num_value[2:0];
                    wr_ptr     <= '0;
                    slot_valid <= '0;   // new count invalidates everything
                end
                default: rx_state <= matrix_io_pkg::rx_get_rows;
            endcase
        end
    end

endmodule

// File: rtl/matrix_printer.sv
`timescale 1ns/10ps

module matrix_printer #(
    parameter int max_slots = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     print_trigger,
    input  logic [3:0]               sw_select,
    input  logic [3:0]               slot_valid,
    input  matrix_io_pkg::elem_t     rd_elem,
    input  matrix_io_pkg::dim_t      rd_rows,
    input  matrix_io_pkg::dim_t      rd_cols,
    output matrix_io_pkg::slot_t     rd_slot,
    output matrix_io_pkg::elem_idx_t rd_idx,
    output matrix_io_pkg::elem_t     tx_data,
    output logic                     tx_start,
    input  logic                     tx_busy
);

    // ========================================================================
    // button sync and edge detect
    // ========================================================================
    logic trig_meta, trig_sync, trig_prev;
    logic trig_edge;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trig_meta <= 1'b0;
            trig_sync <= 1'b0;
            trig_prev <= 1'b0;
        end else begin
            trig_meta <= print_trigger;
            trig_sync <= trig_meta;
            trig_prev <= trig_sync;
        end
    end

    assign trig_edge = trig_sync & ~trig_prev;

    // lowest selected and valid slot wins
    matrix_io_pkg::slot_t sel_slot;
    logic                 sel_found;

    always_comb begin
        sel_slot  = '0;
        sel_found = 1'b0;
        for (int i = 3; i >= 0; i--) begin
            if (i < max_slots && sw_select[i] && slot_valid[i]) begin
                sel_slot  = matrix_io_pkg::slot_t'(i);
                sel_found = 1'b1;
            end
        end
    end

    // digit split of the element being read
    matrix_io_pkg::elem_t hund_c, tens_c, unit_c;

    assign hund_c = rd_elem / 8'd100;
    assign tens_c = (rd_elem % 8'd100) / 8'd10;
    assign unit_c = rd_elem % 8'd10;

    // ========================================================================
    // transmit FSM
    // ========================================================================
    matrix_io_pkg::tx_state_t tx_state;
    matrix_io_pkg::dim_t      out_rows, out_cols;
    matrix_io_pkg::dim_t      row_cnt, col_cnt;
    logic [3:0]               digit_h, digit_t, digit_u;
    logic                     skip_h, skip_t;
    logic                     char_done;

    // tx_busy only rises the edge after tx_start, so hold one extra cycle
    assign char_done = !tx_busy && !tx_start;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_state <= matrix_io_pkg::tx_idle;
            tx_start <= 1'b0;
            tx_data  <= '0;
            rd_slot  <= '0;
            rd_idx   <= '0;
            row_cnt  <= '0;
            col_cnt  <= '0;
            out_rows <= '0;
            out_cols <= '0;
            digit_h  <= '0;
            digit_t  <= '0;
            digit_u  <= '0;
            skip_h   <= 1'b0;
            skip_t   <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (tx_state)
                matrix_io_pkg::tx_idle: if (trig_edge && sel_found) begin
                    rd_slot  <= sel_slot;
                    rd_idx   <= '0;
                    row_cnt  <= '0;
                    col_cnt  <= '0;
                    tx_state <= matrix_io_pkg::tx_load;
                end
                matrix_io_pkg::tx_load: begin
                    if (rd_idx == '0) begin
                        out_rows <= rd_rows;   // latched once per print
                        out_cols <= rd_cols;
                    end
                    digit_h  <= hund_c[3:0];
                    digit_t  <= tens_c[3:0];
                    digit_u  <= unit_c[3:0];
                    skip_h   <= (rd_elem < 8'd100);
                    skip_t   <= (rd_elem < 8'd10);
                    tx_state <= matrix_io_pkg::tx_hundreds;
                end
                matrix_io_pkg::tx_hundreds: begin
                    if (skip_h) begin
                        tx_state <= matrix_io_pkg::tx_tens;
                    end else begin
                        tx_data  <= matrix_io_pkg::ascii_zero + {4'd0, digit_h};
                        tx_start <= 1'b1;
                        tx_state <= matrix_io_pkg::tx_wait_hundreds;
                    end
                end
                matrix_io_pkg::tx_wait_hundreds:
                    if (char_done) tx_state <= matrix_io_pkg::tx_tens;
                matrix_io_pkg::tx_tens: begin
                    if (skip_t) begin
                        tx_state <= matrix_io_pkg::tx_units;
                    end else begin
                        tx_data  <= matrix_io_pkg::ascii_zero + {4'd0, digit_t};
                        tx_start <= 1'b1;
                        tx_state <= matrix_io_pkg::tx_wait_tens;
                    end
                end
                matrix_io_pkg::tx_wait_tens:
                    if (char_done) tx_state <= matrix_io_pkg::tx_units;
                matrix_io_pkg::tx_units: begin   // always sent
                    tx_data  <= matrix_io_pkg::ascii_zero + {4'd0, digit_u};
                    tx_start <= 1'b1;
                    tx_state <= matrix_io_pkg::tx_wait_units;
                end
                matrix_io_pkg::tx_wait_units:
                    if (char_done) tx_state <= matrix_io_pkg::tx_space;
                matrix_io_pkg::tx_space: begin
                    tx_data  <= matrix_io_pkg::ascii_space;
                    tx_start <= 1'b1;
                    tx_state <= matrix_io_pkg::tx_wait_space;
                end
                matrix_io_pkg::tx_wait_space: if (char_done) begin
                    if (col_cnt == out_cols - 3'd1) begin
                        tx_state <= matrix_io_pkg::tx_cr;   // end of row
                    end else begin
                        col_cnt  <= col_cnt + 3'd1;
                        rd_idx   <= rd_idx + 5'd1;
                        tx_state <= matrix_io_pkg::tx_load;
                    end
                end
                matrix_io_pkg::tx_cr: begin
                    tx_data  <= matrix_io_pkg::ascii_cr;
                    tx_start <= 1'b1;
                    tx_state <= matrix_io_pkg::tx_wait_cr;
                end
                matrix_io_pkg::tx_wait_cr:
                    if (char_done) tx_state <= matrix_io_pkg::tx_lf;
                matrix_io_pkg::tx_lf: begin
                    tx_data  <= matrix_io_pkg::ascii_lf;
                    tx_start <= 1'b1;
                    tx_state <= matrix_io_pkg::tx_wait_lf;
                end
                matrix_io_pkg::tx_wait_lf: if (char_done) begin
                    if (row_cnt == out_rows - 3'd1) begin
                        tx_state <= matrix_io_pkg::tx_idle;   // whole matrix sent
                    end else begin
                        row_cnt  <= row_cnt + 3'd1;
                        col_cnt  <= '0;
                        rd_idx   <= rd_idx + 5'd1;
                        tx_state <= matrix_io_pkg::tx_load;
                    end
                end
                default: tx_state <= matrix_io_pkg::tx_idle;
            endcase
        end
    end

endmodule

// File: rtl/matrix_io_top.sv
`timescale 1ns/10ps

module matrix_io_top #(
    parameter int max_slots = 4,
    parameter int max_dim   = 5
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  matrix_io_pkg::elem_t rx_data,
    input  logic                 rx_done,
    input  logic                 config_en,
    input  logic                 print_trigger,
    input  logic [3:0]           sw_select,
    input  logic                 tx_busy,
    output matrix_io_pkg::elem_t tx_data,
    output logic                 tx_start,
    output logic [3:0]           slot_valid
);

    // parser to store
    matrix_io_pkg::elem_t     num_value;
    logic                     num_valid;

    // printer read port into the store
    matrix_io_pkg::slot_t     rd_slot;
    matrix_io_pkg::elem_idx_t rd_idx;
    matrix_io_pkg::elem_t     rd_elem;
    matrix_io_pkg::dim_t      rd_rows, rd_cols;

    ascii_num_parser u_parser (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_data   (rx_data),
        .rx_done   (rx_done),
        .num_value (num_value),
        .num_valid (num_valid)
    );

    matrix_store #(
        .max_slots (max_slots),
        .max_dim   (max_dim)
    ) u_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .num_value  (num_value),
        .num_valid  (num_valid),
        .config_en  (config_en),
        .rd_slot    (rd_slot),
        .rd_idx     (rd_idx),
        .rd_elem    (rd_elem),
        .rd_rows    (rd_rows),
        .rd_cols    (rd_cols),
        .slot_valid (slot_valid)
    );

    matrix_printer #(
        .max_slots (max_slots)
    ) u_printer (
        .clk           (clk),
        .rst_n         (rst_n),
        .print_trigger (print_trigger),
        .sw_select     (sw_select),
        .slot_valid    (slot_valid),
        .rd_elem       (rd_elem),
        .rd_rows       (rd_rows),
        .rd_cols       (rd_cols),
        .rd_slot       (rd_slot),
        .rd_idx        (rd_idx),
        .tx_data       (tx_data),
        .tx_start      (tx_start),
        .tx_busy       (tx_busy)
    );

endmodule

// File: dv/matrix_io_assertions.sv
`timescale 1ns/10ps

module matrix_io_assertions (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 tx_start,
    input logic                 tx_busy,
    input matrix_io_pkg::elem_t tx_data
);

    int fail_cnt = 0;   // read by the testbench at the end of the run

    property start_is_pulse;
        @(posedge clk) disable iff (!rst_n) tx_start |=> !tx_start;
    endproperty

    property no_start_when_busy;
        @(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy;
    endproperty

    // character must not change under the transmitter
    property data_held_when_busy;
        @(posedge clk) disable iff (!rst_n) tx_busy |-> $stable(tx_data);
    endproperty

    a_start_pulse: assert property (start_is_pulse)
        else begin
            fail_cnt++;
            $error("tx_start high on two consecutive cycles");
        end
    a_start_idle: assert property (no_start_when_busy)
        else begin
            fail_cnt++;
            $error("tx_start raised while tx_busy high");
        end
    a_data_stable: assert property (data_held_when_busy)
        else begin
            fail_cnt++;
            $error("tx_data changed while tx_busy high");
        end

endmodule

bind matrix_printer matrix_io_assertions u_tx_checks (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .tx_data  (tx_data)
);

// File: dv/matrix_io_tb.sv
`timescale 1ns/10ps

module matrix_io_tb;

    localparam int max_slots = 4;
    localparam int max_dim   = 5;
    localparam int long_busy = 60;            // busy cycles in the back-pressure test
    // sized for every print as a full 5x5 of three-digit values at long busy
    localparam int n_prints        = 16;
    localparam int max_print_chars = max_dim * max_dim * 4 + max_dim * 2;
    localparam int timeout_cycles  = n_prints * max_print_chars * (long_busy + 6) + 40000;

    logic                 clk = 1'b0;
    logic                 rst_n;
    matrix_io_pkg::elem_t rx_data;
    logic                 rx_done;
    logic                 config_en;
    logic                 print_trigger;
    logic [3:0]           sw_select;
    logic                 tx_busy = 1'b0;
    matrix_io_pkg::elem_t tx_data;
    logic                 tx_start;
    logic [3:0]           slot_valid;

    int    errors    = 0;
    int    checks    = 0;
    int    cycle_cnt = 0;
    int    busy_min  = 1;
    int    busy_max  = 4;
    int    busy_left = 0;
    string captured  = "";                    // every character the UART model took

    // expected slot contents
    int         ref_data [max_slots][max_dim * max_dim];
    int         ref_rows [max_slots];
    int         ref_cols [max_slots];
    logic [3:0] ref_valid;
    int         ref_ptr;
    int         ref_cnt;
    int         ref_last;
    int         elems [$];                    // next matrix, as sent in decimal

    matrix_io_top #(
        .max_slots (max_slots),
        .max_dim   (max_dim)
    ) dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_data       (rx_data),
        .rx_done       (rx_done),
        .config_en     (config_en),
        .print_trigger (print_trigger),
        .sw_select     (sw_select),
        .tx_busy       (tx_busy),
        .tx_data       (tx_data),
        .tx_start      (tx_start),
        .slot_valid    (slot_valid)
    );

    always #4 clk = ~clk;

    // ========================================================================
    // UART transmit model
    // ========================================================================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_busy   <= 1'b0;
            busy_left <= 0;
        end else if (tx_start) begin
            tx_busy   <= 1'b1;                // busy from the edge after tx_start
            busy_left <= busy_min + int'($urandom % (busy_max - busy_min + 1));
            captured  = {captured, $sformatf("%c", tx_data)};
        end else if (busy_left > 1) begin
            busy_left <= busy_left - 1;
        end else begin
            tx_busy   <= 1'b0;
            busy_left <= 0;
        end
    end

    initial begin : watchdog
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run did not end within %0d cycles, %0d errors so far",
                 cycle_cnt, errors);
        $display("Test failed");
        $finish;
    end

    // ========================================================================
    // helpers
    // ========================================================================
    function automatic string hex_text(input string s);
        string h;
        h = "";
        for (int i = 0; i < s.len(); i++)
            h = {h, $sformatf("%02h", s[i])};
        return h;
    endfunction

    // decimal, no leading zeros, space after each element, CR LF per row
    function automatic string format_matrix(input int slot);
        string s;
        s = "";
        for (int r = 0; r < ref_rows[slot]; r++) begin
            for (int c = 0; c < ref_cols[slot]; c++)
                s = {s, $sformatf("%0d ", ref_data[slot][r * ref_cols[slot] + c])};
            s = {s, $sformatf("%c%c", 8'h0d, 8'h0a)};
        end
        return s;
    endfunction

    task automatic reset_dut();
        @(posedge clk);
        rst_n         <= 1'b0;
        rx_done       <= 1'b0;
        config_en     <= 1'b0;
        print_trigger <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n     <= 1'b1;
        ref_valid = '0;
        ref_ptr   = 0;
        ref_cnt   = 2;                        // slot count after reset
        ref_last  = 0;
    endtask

    task automatic send_byte(input matrix_io_pkg::elem_t b);
        @(posedge clk);
        rx_data <= b;
        rx_done <= 1'b1;
        @(posedge clk);
        rx_done <= 1'b0;
    endtask

    task automatic send_text(input string s);
        for (int i = 0; i < s.len(); i++)
            send_byte(s[i]);
        repeat (3) @(posedge clk);           // let the store take the last number
    endtask

    task automatic fill_random(input int n);
        elems.delete();
        repeat (n) elems.push_back(int'($urandom % 400));   // some above 255
    endtask

    // valid dimensions only
    task automatic send_matrix(input int rows, input int cols);
        string txt;
        txt = $sformatf("%0d %0d%c", rows, cols, 8'h0a);
        for (int i = 0; i < rows * cols; i++) begin
            if (i % cols == cols - 1)
                txt = {txt, $sformatf("%0d%c%c", elems[i], 8'h0d, 8'h0a)};
            else
                txt = {txt, $sformatf("%0d ", elems[i])};
        end
        send_text(txt);
        for (int i = 0; i < rows * cols; i++)
            ref_data[ref_ptr][i] = elems[i] % 256;
        ref_rows[ref_ptr]  = rows;
        ref_cols[ref_ptr]  = cols;
        ref_valid[ref_ptr] = 1'b1;
        ref_last           = ref_ptr;
        ref_ptr            = (ref_ptr + 1) % ref_cnt;
    endtask

    task automatic configure(input int value);
        @(posedge clk);
        config_en <= 1'b1;
        repeat (2) @(posedge clk);
        send_text($sformatf("%0d ", value));
        config_en <= 1'b0;
        repeat (2) @(posedge clk);
        ref_cnt   = (value < 1) ? 1 : (value > max_slots) ? max_slots : value;
        ref_ptr   = 0;
        ref_valid = '0;
    endtask

    task automatic check_valid(input string tag);
        @(negedge clk);
        checks++;
        assert (slot_valid === ref_valid) else begin
            errors++;
            $display("Mismatch slot_valid (%s): got 0x%h expected 0x%h",
                     tag, slot_valid, ref_valid);
        end
    endtask

    task automatic print_check(input logic [3:0] sw, input string tag);
        int    sel;
        int    start;
        int    waited;
        int    limit;
        string expected;
        string got;
        sel = -1;
        for (int i = max_slots - 1; i >= 0; i--)
            if (sw[i] && ref_valid[i])
                sel = i;                      // lowest selected valid slot
        if (sel < 0)
            expected = "";
        else
            expected = format_matrix(sel);
        start = captured.len();
        @(posedge clk);
        sw_select     <= sw;
        print_trigger <= 1'b1;
        repeat (4) @(posedge clk);
        print_trigger <= 1'b0;
        limit  = expected.len() * (busy_max + 8) + 40;
        waited = 0;
        while (captured.len() - start < expected.len() && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (waited < limit) else begin
            errors++;
            $display("Print (%s) did not finish within %0d cycles", tag, limit);
        end
        repeat (busy_max + 16) @(negedge clk);   // extra characters would land here
        got = captured.substr(start, captured.len() - 1);
        checks++;
        assert (got == expected) else begin
            errors++;
            $display("Mismatch tx_data (%s): got 0x%s expected 0x%s",
                     tag, hex_text(got), hex_text(expected));
        end
    endtask

    // ========================================================================
    // directed tests
    // ========================================================================
    task automatic store_and_print();
        elems = '{1, 2, 3, 4};
        send_matrix(2, 2);
        check_valid("first 2x2");
        print_check(4'b0001, "first 2x2");
    endtask

    task automatic digit_formatting();
        elems = '{0, 9, 10, 99, 100, 255, 300, 1};
        elems[7] = int'($urandom % 256);
        send_matrix(2, 4);
        check_valid("digit edges");
        print_check(4'(1 << ref_last), "digit edges");
        fill_random(15);
        send_matrix(3, 5);
        print_check(4'(1 << ref_last), "random 3x5");
    endtask

    // a wrongly accepted count would swallow the numbers after it
    task automatic bad_dimensions();
        send_text("0 ");
        check_valid("row count 0");
        send_text("3 7 ");                    // bad column count
        check_valid("column count 7");
        send_text("6 ");
        check_valid("row count 6");
        fill_random(3);
        send_matrix(1, 3);
        check_valid("after bad dims");
        print_check(4'(1 << ref_last), "after bad dims");
    endtask

    task automatic round_robin();
        reset_dut();
        fill_random(4);
        send_matrix(2, 2);
        fill_random(6);
        send_matrix(3, 2);
        fill_random(5);
        send_matrix(1, 5);                    // wraps onto slot 0
        check_valid("round robin");
        print_check(4'b0001, "slot 0 overwritten");
        print_check(4'b0010, "slot 1 kept");
    endtask

    task automatic slot_config();
        configure(3);
        check_valid("config 3 clears");
        repeat (3) begin
            fill_random(6);
            send_matrix(2, 3);
        end
        check_valid("three slots");
        print_check(4'b0110, "priority slot 1");
        print_check(4'b1111, "priority slot 0");
        print_check(4'b1000, "slot 3 unused");
        configure(9);
        repeat (5) begin
            fill_random(4);
            send_matrix(4, 1);
        end
        check_valid("clamped to 4");
        print_check(4'b1000, "slot 3 after clamp");
        print_check(4'b0001, "slot 0 after wrap");
    endtask

    task automatic back_pressure();
        busy_min = 20;
        busy_max = long_busy;
        fill_random(9);
        send_matrix(3, 3);
        print_check(4'(1 << ref_last), "long tx_busy");
        busy_min = 1;
        busy_max = 4;
    endtask

    initial begin
        void'($urandom(32'h883888db));
        rst_n         = 1'b0;
        rx_data       = '0;
        rx_done       = 1'b0;
        config_en     = 1'b0;
        print_trigger = 1'b0;
        sw_select     = '0;
        reset_dut();
        store_and_print();
        digit_formatting();
        bad_dimensions();
        round_robin();
        slot_config();
        back_pressure();
        repeat (4) @(posedge clk);
        errors += dut0.u_printer.u_tx_checks.fail_cnt;   // bound handshake checks
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: filelist.f
rtl/matrix_io_pkg.sv
rtl/ascii_num_parser.sv
rtl/matrix_store.sv
rtl/matrix_printer.sv
rtl/matrix_io_top.sv
dv/matrix_io_assertions.sv
dv/matrix_io_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := matrix_io_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := Test completed successfully

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
